// ==== proc_defines.svh ====
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// Datapath word width
`define DATA_W      16
`define NUM_REGS    8
// Issue queue entries, equal to the sender's starting credits
`define IQ_DEPTH    4
`define RES_CREDITS 2

`endif

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_SIIC  = 5'b00010,
      OP_RTI   = 5'b00011,
      OP_J     = 5'b00100,
      OP_JR    = 5'b00101,
      OP_JAL   = 5'b00110,
      OP_JALR  = 5'b00111,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_BLTZ  = 5'b01110,
      OP_BGEZ  = 5'b01111,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_SLBI  = 5'b10010,
      OP_STU   = 5'b10011,
      OP_ROLI  = 5'b10100,
      OP_SLLI  = 5'b10101,
      OP_RORI  = 5'b10110,
      OP_SRLI  = 5'b10111,
      OP_LBI   = 5'b11000,
      OP_BTR   = 5'b11001,
      OP_SHFT  = 5'b11010,  // ROL, SLL, ROR, SRL by func
      OP_ARITH = 5'b11011,  // ADD, SUB, XOR, ANDN by func
      OP_SEQ   = 5'b11100,
      OP_SLT   = 5'b11101,
      OP_SLE   = 5'b11110,
      OP_SCO   = 5'b11111
   } opcode_e;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rs;
      logic [2:0] rd;       // Upper three bits of imm8 for LBI and branches
      logic [4:0] imm;
   } i_fmt_t;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_fmt_t;

   typedef union packed {
      i_fmt_t i;
      r_fmt_t r;
   } instr_u;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

   typedef enum logic [2:0] {
      ALU_ROL  = 3'b000,
      ALU_SLL  = 3'b001,
      ALU_ROR  = 3'b010,
      ALU_SRL  = 3'b011,
      ALU_ADD  = 3'b100,
      ALU_ANDN = 3'b101,  // AND of the inverted-or-not operands
      ALU_BTR  = 3'b110,
      ALU_XOR  = 3'b111
   } alu_op_e;

   typedef enum logic [1:0] {WB_ALU, WB_SET, WB_IMM, WB_SLBI} wb_sel_e;

   typedef enum logic [1:0] {SET_CO, SET_EQ, SET_LT, SET_LE} set_sel_e;

   typedef enum logic [1:0] {BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cnd_e;

   // zext imm5, sext imm5, sext imm8, sext imm11
   typedef enum logic [1:0] {SX_ZEXT5, SX_SEXT5, SX_SEXT8, SX_SEXT11} sext_op_e;

   typedef struct packed {
      logic       wr_en;
      logic [1:0] wr_reg_sel;  // 00 rd, 01 I-format rd, 10 rs, 11 R7
      wb_sel_e    wb_sel;
      set_sel_e   set_sel;
      logic       oprnd_sel;   // Immediate as second operand
      sext_op_e   sext_op;
      alu_op_e    alu_op;
      logic       inv_a;
      logic       inv_b;
      logic       cin;
      logic       alu_sign;
      logic       br_instr;
      br_cnd_e    br_cnd;
      logic       halt;
      logic       err;
   } ctrl_t;

endpackage

`default_nettype wire

// ==== exec_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface exec_if;
   logic            valid;  // Queue head present
   isa_pkg::instr_u instr;
   ctrl_pkg::ctrl_t ctrl;
   logic            issue;  // Head consumed this cycle

   modport decoder (
      output valid,
      output instr,
      output ctrl
   );

   modport execute (
      input  valid,
      input  instr,
      input  ctrl,
      output issue
   );
endinterface

`default_nettype wire

// ==== control.sv ====
`timescale 1ns/100ps
`default_nettype none

module control (
   input  logic            valid,
   input  isa_pkg::instr_u instr,
   exec_if.decoder         ex
);

   ctrl_pkg::ctrl_t c;

   assign ex.valid = valid;
   assign ex.instr = instr;
   assign ex.ctrl  = c;

   always_comb begin
      c          = '0;
      c.alu_sign = 1'b1;  // Signed compares unless SCO

      case (instr.i.opcode)
         isa_pkg::OP_HALT: begin
            c.halt = 1'b1;
         end
         isa_pkg::OP_NOP: begin
            // Retires with no register write
         end
         isa_pkg::OP_ADDI, isa_pkg::OP_SUBI: begin
            c.wr_en      = 1'b1;
            c.wr_reg_sel = 2'b01;
            c.oprnd_sel  = 1'b1;
            c.sext_op    = ctrl_pkg::SX_SEXT5;
            c.alu_op     = ctrl_pkg::ALU_ADD;
            c.inv_a      = instr.i.opcode[0];  // SUBI computes imm - rs
            c.cin        = instr.i.opcode[0];
         end
         isa_pkg::OP_XORI: begin
            c.wr_en      = 1'b1;
            c.wr_reg_sel = 2'b01;
            c.oprnd_sel  = 1'b1;
            c.alu_op     = ctrl_pkg::ALU_XOR;
         end
         isa_pkg::OP_ANDNI: begin
            c.wr_en      = 1'b1;
            c.wr_reg_sel = 2'b01;
            c.oprnd_sel  = 1'b1;
            c.alu_op     = ctrl_pkg::ALU_ANDN;
            c.inv_b      = 1'b1;
         end
         isa_pkg::OP_ROLI, isa_pkg::OP_SLLI, isa_pkg::OP_RORI, isa_pkg::OP_SRLI: begin
            c.wr_en      = 1'b1;
            c.wr_reg_sel = 2'b01;
            c.oprnd_sel  = 1'b1;
            c.alu_op     = ctrl_pkg::alu_op_e'({1'b0, instr.i.opcode[1:0]});
         end
         isa_pkg::OP_BTR: begin
            c.wr_en  = 1'b1;
            c.alu_op = ctrl_pkg::ALU_BTR;
         end
         isa_pkg::OP_ARITH: begin
            c.wr_en  = 1'b1;
            c.alu_op = (instr.r.func[1] == 1'b0) ? ctrl_pkg::ALU_ADD :
                       (instr.r.func[0] == 1'b0) ? ctrl_pkg::ALU_XOR : ctrl_pkg::ALU_ANDN;
            c.inv_a  = ~instr.r.func[1] & instr.r.func[0];  // SUB is rt - rs
            c.inv_b  = instr.r.func[1] & instr.r.func[0];
            c.cin    = ~instr.r.func[1] & instr.r.func[0];
         end
         isa_pkg::OP_SHFT: begin
            c.wr_en  = 1'b1;
            c.alu_op = ctrl_pkg::alu_op_e'({1'b0, instr.r.func});
         end
         isa_pkg::OP_SEQ, isa_pkg::OP_SLT, isa_pkg::OP_SLE: begin
            c.wr_en  = 1'b1;
            c.wb_sel = ctrl_pkg::WB_SET;
            c.alu_op = ctrl_pkg::ALU_ADD;
            c.inv_b  = 1'b1;  // rs - rt
            c.cin    = 1'b1;
            c.set_sel = (instr.i.opcode == isa_pkg::OP_SEQ) ? ctrl_pkg::SET_EQ :
                        (instr.i.opcode == isa_pkg::OP_SLT) ? ctrl_pkg::SET_LT :
                        ctrl_pkg::SET_LE;
         end
         isa_pkg::OP_SCO: begin
            c.wr_en    = 1'b1;
            c.wb_sel   = ctrl_pkg::WB_SET;
            c.set_sel  = ctrl_pkg::SET_CO;
            c.alu_op   = ctrl_pkg::ALU_ADD;
            c.alu_sign = 1'b0;
         end
         isa_pkg::OP_BEQZ, isa_pkg::OP_BNEZ, isa_pkg::OP_BLTZ, isa_pkg::OP_BGEZ: begin
            c.br_instr = 1'b1;
            c.sext_op  = ctrl_pkg::SX_SEXT8;
            c.br_cnd   = ctrl_pkg::br_cnd_e'(instr.i.opcode[1:0]);
         end
         isa_pkg::OP_LBI, isa_pkg::OP_SLBI: begin
            c.wr_en      = 1'b1;
            c.wr_reg_sel = 2'b10;  // Destination in the rs field
            c.sext_op    = ctrl_pkg::SX_SEXT8;
            c.wb_sel     = (instr.i.opcode == isa_pkg::OP_LBI) ? ctrl_pkg::WB_IMM :
                           ctrl_pkg::WB_SLBI;
         end
         default: begin
            c.err = 1'b1;  // Memory, jumps, siic and reserved
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== issue_queue.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "proc_defines.svh"

module issue_queue (
   input  logic            clk,
   input  logic            reset,
   input  logic            in_valid,
   input  isa_pkg::instr_u in_instr,
   input  logic            pop,
   output logic            head_valid,
   output isa_pkg::instr_u head_instr,
   output logic            in_credit
);

   localparam int PTR_W = $clog2(`IQ_DEPTH);
   localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

   isa_pkg::instr_u  mem [`IQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   assign head_valid = (count != '0);
   assign head_instr = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (in_valid) begin
         mem[wr_ptr] <= in_instr;  // Sender credits keep this from overflowing
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         in_credit <= 1'b0;
      end else begin
         in_credit <= pop;  // One credit back per entry leaving
         if (in_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({in_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "proc_defines.svh"

module reg_file (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [$clog2(`NUM_REGS)-1:0] rs_addr,
   input  logic [$clog2(`NUM_REGS)-1:0] rt_addr,
   output logic [`DATA_W-1:0]           rs_data,
   output logic [`DATA_W-1:0]           rt_data,
   input  logic                         wr_en,
   input  logic [$clog2(`NUM_REGS)-1:0] wr_addr,
   input  logic [`DATA_W-1:0]           wr_data
);

   logic [`DATA_W-1:0] regs [`NUM_REGS];

   // Reads see a write from the previous edge, so back to back issue is safe
   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "proc_defines.svh"

module exec_unit (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         res_credit,
   exec_if.execute                      ex,
   output logic [$clog2(`NUM_REGS)-1:0] rs_addr,
   output logic [$clog2(`NUM_REGS)-1:0] rt_addr,
   input  logic [`DATA_W-1:0]           rs_data,
   input  logic [`DATA_W-1:0]           rt_data,
   output logic                         wr_en,
   output logic [$clog2(`NUM_REGS)-1:0] wr_addr,
   output logic [`DATA_W-1:0]           wr_data,
   output logic                         res_valid,
   output logic                         res_wr_en,
   output logic [$clog2(`NUM_REGS)-1:0] res_reg,
   output logic [`DATA_W-1:0]           res_data,
   output logic                         res_br_taken,
   output logic [`DATA_W-1:0]           res_offset,
   output logic                         res_halt,
   output logic                         res_err
);

   localparam int CRED_W = $clog2(`RES_CREDITS + 1);

   logic [7:0]                   imm8;
   logic [10:0]                  imm11;
   logic [`DATA_W-1:0]           imm_ext;
   logic [`DATA_W-1:0]           opnd_b;
   logic [`DATA_W-1:0]           a_in;
   logic [`DATA_W-1:0]           b_in;
   logic [`DATA_W:0]             sum_full;
   logic [`DATA_W-1:0]           sum;
   logic                         carry;
   logic [$clog2(`DATA_W)-1:0]   shamt;
   logic [2*`DATA_W-1:0]         rot_l;
   logic [2*`DATA_W-1:0]         rot_r;
   logic [`DATA_W-1:0]           alu_out;
   logic                         eq;
   logic                         lt;
   logic                         set_bit;
   logic                         taken;
   logic                         issue;
   logic [CRED_W-1:0]            credits;

   assign rs_addr = ex.instr.r.rs;
   assign rt_addr = ex.instr.r.rt;

   assign imm8  = {ex.instr.i.rd, ex.instr.i.imm};
   assign imm11 = {ex.instr.i.rs, ex.instr.i.rd, ex.instr.i.imm};

   always_comb begin
      case (ex.ctrl.sext_op)
         ctrl_pkg::SX_ZEXT5: imm_ext = {{(`DATA_W-5){1'b0}}, ex.instr.i.imm};
         ctrl_pkg::SX_SEXT5: imm_ext = {{(`DATA_W-5){ex.instr.i.imm[4]}}, ex.instr.i.imm};
         ctrl_pkg::SX_SEXT8: imm_ext = {{(`DATA_W-8){imm8[7]}}, imm8};
         default:            imm_ext = {{(`DATA_W-11){imm11[10]}}, imm11};
      endcase
   end

   assign opnd_b   = ex.ctrl.oprnd_sel ? imm_ext : rt_data;
   assign a_in     = ex.ctrl.inv_a ? ~rs_data : rs_data;
   assign b_in     = ex.ctrl.inv_b ? ~opnd_b : opnd_b;
   assign sum_full = a_in + b_in + ex.ctrl.cin;
   assign sum      = sum_full[`DATA_W-1:0];
   assign carry    = sum_full[`DATA_W];
   assign shamt    = opnd_b[$clog2(`DATA_W)-1:0];  // Low bits of rt or imm
   assign rot_l    = {a_in, a_in} << shamt;
   assign rot_r    = {a_in, a_in} >> shamt;

   always_comb begin
      case (ex.ctrl.alu_op)
         ctrl_pkg::ALU_ROL:  alu_out = rot_l[2*`DATA_W-1:`DATA_W];
         ctrl_pkg::ALU_SLL:  alu_out = a_in << shamt;
         ctrl_pkg::ALU_ROR:  alu_out = rot_r[`DATA_W-1:0];
         ctrl_pkg::ALU_SRL:  alu_out = a_in >> shamt;
         ctrl_pkg::ALU_ADD:  alu_out = sum;
         ctrl_pkg::ALU_ANDN: alu_out = a_in & b_in;
         ctrl_pkg::ALU_BTR:  alu_out = {<<{a_in}};
         default:            alu_out = a_in ^ b_in;
      endcase
   end

   // Compare on rs - rt, sign taken from rs when the operand signs differ
   assign eq = (sum == '0);
   assign lt = ex.ctrl.alu_sign ?
               ((rs_data[`DATA_W-1] ^ opnd_b[`DATA_W-1]) ? rs_data[`DATA_W-1] : sum[`DATA_W-1]) :
               ~carry;

   always_comb begin
      case (ex.ctrl.set_sel)
         ctrl_pkg::SET_CO: set_bit = carry;
         ctrl_pkg::SET_EQ: set_bit = eq;
         ctrl_pkg::SET_LT: set_bit = lt;
         default:          set_bit = lt | eq;
      endcase
   end

   always_comb begin
      case (ex.ctrl.br_cnd)
         ctrl_pkg::BR_EQZ: taken = (rs_data == '0);
         ctrl_pkg::BR_NEZ: taken = (rs_data != '0);
         ctrl_pkg::BR_LTZ: taken = rs_data[`DATA_W-1];
         default:          taken = ~rs_data[`DATA_W-1];
      endcase
   end

   always_comb begin
      case (ex.ctrl.wb_sel)
         ctrl_pkg::WB_ALU: wr_data = alu_out;
         ctrl_pkg::WB_SET: wr_data = {{(`DATA_W-1){1'b0}}, set_bit};
         ctrl_pkg::WB_IMM: wr_data = imm_ext;
         default:          wr_data = {rs_data[`DATA_W-9:0], imm8};  // (rs << 8) | imm8
      endcase
   end

   always_comb begin
      case (ex.ctrl.wr_reg_sel)
         2'b00:   wr_addr = ex.instr.r.rd;
         2'b01:   wr_addr = ex.instr.i.rd;
         2'b10:   wr_addr = ex.instr.i.rs;
         default: wr_addr = '1;  // R7 link register
      endcase
   end

   assign issue    = ex.valid & (credits != '0);
   assign ex.issue = issue;
   assign wr_en    = issue & ex.ctrl.wr_en;

   always_ff @(posedge clk) begin
      if (reset) begin
         credits   <= CRED_W'(`RES_CREDITS);
         res_valid <= 1'b0;
      end else begin
         credits   <= credits - CRED_W'(issue) + CRED_W'(res_credit);
         res_valid <= issue;  // High for one cycle per issued word
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         res_wr_en    <= ex.ctrl.wr_en;
         res_reg      <= wr_addr;
         res_data     <= wr_data;
         res_br_taken <= ex.ctrl.br_instr & taken;
         res_offset   <= imm_ext;
         res_halt     <= ex.ctrl.halt;
         res_err      <= ex.ctrl.err;
      end
   end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "proc_defines.svh"

module exec_core (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         in_valid,
   input  logic [`DATA_W-1:0]           in_instr,
   output logic                         in_credit,
   input  logic                         res_credit,
   output logic                         res_valid,
   output logic                         res_wr_en,
   output logic [$clog2(`NUM_REGS)-1:0] res_reg,
   output logic [`DATA_W-1:0]           res_data,
   output logic                         res_br_taken,
   output logic [`DATA_W-1:0]           res_offset,
   output logic                         res_halt,
   output logic                         res_err
);

   logic                         head_valid;
   isa_pkg::instr_u              head_instr;
   logic [$clog2(`NUM_REGS)-1:0] rs_addr;
   logic [$clog2(`NUM_REGS)-1:0] rt_addr;
   logic [`DATA_W-1:0]           rs_data;
   logic [`DATA_W-1:0]           rt_data;
   logic                         wr_en;
   logic [$clog2(`NUM_REGS)-1:0] wr_addr;
   logic [`DATA_W-1:0]           wr_data;

   exec_if ex_bus ();

   issue_queue u_iq (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_instr   (in_instr),
      .pop        (ex_bus.issue),
      .head_valid (head_valid),
      .head_instr (head_instr),
      .in_credit  (in_credit)
   );

   control u_ctrl (
      .valid (head_valid),
      .instr (head_instr),
      .ex    (ex_bus.decoder)
   );

   reg_file u_rf (
      .clk     (clk),
      .reset   (reset),
      .rs_addr (rs_addr),
      .rt_addr (rt_addr),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

   exec_unit u_exec (
      .clk          (clk),
      .reset        (reset),
      .res_credit   (res_credit),
      .ex           (ex_bus.execute),
      .rs_addr      (rs_addr),
      .rt_addr      (rt_addr),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .res_valid    (res_valid),
      .res_wr_en    (res_wr_en),
      .res_reg      (res_reg),
      .res_data     (res_data),
      .res_br_taken (res_br_taken),
      .res_offset   (res_offset),
      .res_halt     (res_halt),
      .res_err      (res_err)
   );

endmodule

`default_nettype wire

// ==== exec_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "proc_defines.svh"

module exec_core_tb;

   localparam int N_TRACE     = 29;
   localparam int CYCLE_LIMIT = 20 * N_TRACE;
   localparam int REG_W       = $clog2(`NUM_REGS);

   logic               clk;
   logic               reset;
   logic               in_valid;
   logic [`DATA_W-1:0] in_instr;
   logic               in_credit;
   logic               res_credit;
   logic               res_valid;
   logic               res_wr_en;
   logic [REG_W-1:0]   res_reg;
   logic [`DATA_W-1:0] res_data;
   logic               res_br_taken;
   logic [`DATA_W-1:0] res_offset;
   logic               res_halt;
   logic               res_err;

   logic [51:0] trace_mem [N_TRACE];  // Instr, wr_en, reg, data, taken, halt, err
   int          seed;
   logic [31:0] rnd;
   int          cycles;
   int          sent;
   int          send_credits;     // Words the sender may still put in flight
   int          res_count;
   int          pending_credits;  // Results consumed, credit not yet returned
   int          errors;
   int          tests_ok;
   int          tests_bad;

   exec_core dut (
      .clk          (clk),
      .reset        (reset),
      .in_valid     (in_valid),
      .in_instr     (in_instr),
      .in_credit    (in_credit),
      .res_credit   (res_credit),
      .res_valid    (res_valid),
      .res_wr_en    (res_wr_en),
      .res_reg      (res_reg),
      .res_data     (res_data),
      .res_br_taken (res_br_taken),
      .res_offset   (res_offset),
      .res_halt     (res_halt),
      .res_err      (res_err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic compare_field(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_result(input int idx);
      logic [51:0] line;
      logic [15:0] instr;
      int          errs_before;
      line        = trace_mem[idx];
      instr       = line[51:36];
      errs_before = errors;
      compare_field("res_wr_en", 16'(res_wr_en), 16'(line[32]));
      if (line[32]) begin  // Destination only matters on a write
         compare_field("res_reg", 16'(res_reg), 16'(line[30:28]));
         compare_field("res_data", res_data, line[27:12]);
      end
      compare_field("res_br_taken", 16'(res_br_taken), 16'(line[8]));
      compare_field("res_halt", 16'(res_halt), 16'(line[4]));
      compare_field("res_err", 16'(res_err), 16'(line[0]));
      if (instr[15:13] == 3'b011) begin  // Branch opcodes 01100 to 01111
         compare_field("res_offset", res_offset, {{8{instr[7]}}, instr[7:0]});
      end
      if (errors == errs_before) begin
         tests_ok++;
         $display("test %0d instr %h ok", idx, instr);
      end else begin
         tests_bad++;
         $display("test %0d instr %h mismatch", idx, instr);
      end
   endtask

   task automatic sample_outputs();
      if (in_credit) begin
         send_credits++;
         assert (send_credits <= `IQ_DEPTH) else begin
            $display("More input credits came back than words were sent at %0t", $time);
            errors++;
         end
      end
      if (res_valid) begin
         assert (res_count < N_TRACE) else begin
            $display("Extra result at %0t after the trace ended", $time);
            errors++;
         end
         if (res_count < N_TRACE) begin
            check_result(res_count);
         end
         res_count++;
         pending_credits++;
      end
   endtask

   task automatic drive_inputs();
      rnd        = $random(seed);
      res_credit = 1'b0;
      if (pending_credits > 0 && rnd[1:0] == 2'b00) begin  // Slow receiver
         res_credit = 1'b1;
         pending_credits--;
      end
      if (sent < N_TRACE && send_credits > 0) begin
         in_valid = 1'b1;
         in_instr = trace_mem[sent][51:36];
         sent++;
         send_credits--;
      end else begin
         in_valid = 1'b0;
      end
   endtask

   initial begin
      seed            = 32'hce38eb02;
      reset           = 1'b1;
      in_valid        = 1'b0;
      in_instr        = '0;
      res_credit      = 1'b0;
      cycles          = 0;
      sent            = 0;
      send_credits    = `IQ_DEPTH;
      res_count       = 0;
      pending_credits = 0;
      errors          = 0;
      tests_ok        = 0;
      tests_bad       = 0;
      $readmemh("exec_trace.txt", trace_mem);
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      while (res_count < N_TRACE && cycles < CYCLE_LIMIT) begin
         @(negedge clk);
         cycles++;
         sample_outputs();
         drive_inputs();
      end
      if (res_count < N_TRACE) begin
         $display("Timeout after %0d cycles with %0d of %0d results seen",
                  cycles, res_count, N_TRACE);
         errors++;
      end else begin
         repeat (4) begin  // Watch for stray results
            @(negedge clk);
            sample_outputs();
            drive_inputs();
         end
         assert (send_credits == `IQ_DEPTH) else begin
            $display("Sender holds %0d of %0d input credits at the end",
                     send_credits, `IQ_DEPTH);
            errors++;
         end
      end
      $display("Results %0d of %0d, tests ok %0d, tests with mismatches %0d, errors %0d",
               res_count, N_TRACE, tests_ok, tests_bad, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
exec_if.sv
control.sv
issue_queue.sv
reg_file.sv
exec_unit.sv
exec_core.sv
exec_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the exec_core testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module exec_core_tb -f flist.f \
   -o exec_core_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/exec_core_sim > sim.log 2>&1
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log && exit 0 || exit 1

// ==== exec_trace.txt ====
// instr _ wr_en _ reg _ data _ taken _ halt _ err, one result per line in issue order
// Registers start at zero after reset
C105_1_1_0005_0_0_0 // lbi r1, 0x05
C2F3_1_2_FFF3_0_0_0 // lbi r2, 0xf3
9134_1_1_0534_0_0_0 // slbi r1, 0x34
4167_1_3_053B_0_0_0 // addi r3, r1, 7
499F_1_4_FACB_0_0_0 // subi r4, r1, -1
51BF_1_5_052B_0_0_0 // xori r5, r1, 0x1f
59CF_1_6_0530_0_0_0 // andni r6, r1, 0x0f
A2E4_1_7_FF3F_0_0_0 // roli r7, r2, 4
BA64_1_3_0FFF_0_0_0 // srli r3, r2, 4
A983_1_4_29A0_0_0_0 // slli r4, r1, 3
B1A4_1_5_4053_0_0_0 // rori r5, r1, 4
D958_1_6_0527_0_0_0 // add r6, r1, r2
DA2D_1_3_0541_0_0_0 // sub r3, r2, r1
DA33_1_4_FAC3_0_0_0 // andn r4, r2, r1
D956_1_5_FAC7_0_0_0 // xor r5, r1, r2
D27F_1_7_7FF9_0_0_0 // srl r7, r2, r3
C918_1_6_2CA0_0_0_0 // btr r6, r1
E12C_1_3_0001_0_0_0 // seq r3, r1, r1
EA30_1_4_0001_0_0_0 // slt r4, r2, r1
F154_1_5_0000_0_0_0 // sle r5, r1, r2
FA38_1_6_0001_0_0_0 // sco r6, r2, r1
6510_0_0_0000_1_0_0 // beqz r5, 0x10
6DF0_0_0_0000_0_0_0 // bnez r5, 0xf0
7280_0_0_0000_1_0_0 // bltz r2, 0x80
7A7F_0_0_0000_0_0_0 // bgez r2, 0x7f
0800_0_0_0000_0_0_0 // nop
8800_0_0_0000_0_0_1 // ld
2000_0_0_0000_0_0_1 // j
0000_0_0_0000_0_1_0 // halt
